// File: source/vic_pkg.sv
package vic_pkg;

   ////////////////////////////////////////////////////////////
   // Sizes
   ////////////////////////////////////////////////////////////

   localparam int NUM_IRQ         = 8;  // Request lines
   localparam int VEC_W           = 3;  // Bits per vector number
   localparam int ISR_SHIFT       = 4;  // Routine slots are 16 bytes apart
   localparam int QUEUE_DEPTH_DEF = 4;

   ////////////////////////////////////////////////////////////
   // Types
   ////////////////////////////////////////////////////////////

   typedef logic [VEC_W-1:0] vec_t;

   // Execute stage context, saved at entry and restored at return
   typedef struct packed
   {
      logic [31:0] pc;
      logic [3:0]  ccodes;
   } cpu_ctx_t;

   typedef enum logic [1:0]
   {
      ST_IDLE   = 2'd0,  // No routine running
      ST_ENTER  = 2'd1,  // Redirect out, waiting for fetch to take it
      ST_IN_ISR = 2'd2   // Routine body executing
   } vic_state_t;

endpackage

// File: source/irq_prio.sv
`timescale 1ns/10ps

module irq_prio
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic [vic_pkg::NUM_IRQ-1:0] i_irq,
   input  logic                        i_full,
   output logic                        o_push,
   output vic_pkg::vec_t               o_push_vec
);

   import vic_pkg::*;

   logic [NUM_IRQ-1:0] irq_s;    // Sampled lines
   logic [NUM_IRQ-1:0] irq_p;    // Previous sample
   logic [NUM_IRQ-1:0] rise;
   logic [NUM_IRQ-1:0] pending;
   logic [NUM_IRQ-1:0] clr_mask;
   vec_t               sel_vec;
   logic               push_now;

   assign rise = irq_s & ~irq_p;

   // Fixed priority, lowest index wins
   always_comb
   begin
      sel_vec = '0;
      for (int i = NUM_IRQ - 1; i >= 0; i--)
      begin
         if (pending[i])
         begin
            sel_vec = vec_t'(i);
         end
      end
   end

   // Skip a cycle after each push so the full flag has caught up
   assign push_now = (|pending) && !i_full && !o_push;
   assign clr_mask = push_now ? (NUM_IRQ'(1) << sel_vec) : '0;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         irq_s   <= '0;
         irq_p   <= '0;
         pending <= '0;
         o_push  <= 1'b0;
      end
      else
      begin
         irq_s   <= i_irq;
         irq_p   <= irq_s;
         pending <= (pending & ~clr_mask) | rise;  // New edge wins over clear
         o_push  <= push_now;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push_now)
      begin
         o_push_vec <= sel_vec;
      end
   end

endmodule

// File: source/irq_queue.sv
`timescale 1ns/10ps

module irq_queue
#(
   parameter int DEPTH = vic_pkg::QUEUE_DEPTH_DEF
)
(
   input  logic          clk,
   input  logic          rst,
   input  logic          i_push,
   input  vic_pkg::vec_t i_push_vec,
   input  logic          i_pop,
   output vic_pkg::vec_t o_head,
   output logic          o_empty,
   output logic          o_full
);

   import vic_pkg::*;

   vec_t                   mem [DEPTH];
   logic [$clog2(DEPTH)-1:0] wr_ptr;
   logic [$clog2(DEPTH)-1:0] rd_ptr;
   logic [$clog2(DEPTH):0]   count;
   logic                     do_push;
   logic                     do_pop;

   assign o_empty = (count == '0);
   assign o_full  = (count == ($clog2(DEPTH) + 1)'(DEPTH));
   assign o_head  = mem[rd_ptr];

   assign do_push = i_push && !o_full;   // Dropped when full
   assign do_pop  = i_pop && !o_empty;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
         begin
            wr_ptr <= wr_ptr + 1'b1;  // Wraps for power of two depth
         end
         if (do_pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_push)
      begin
         mem[wr_ptr] <= i_push_vec;
      end
   end

endmodule

// File: source/vic_ctrl.sv
`timescale 1ns/10ps

module vic_ctrl
(
   input  logic              clk,
   input  logic              rst,
   input  vic_pkg::vec_t     i_head,
   input  logic              i_empty,
   output logic              o_pop,
   input  vic_pkg::cpu_ctx_t i_ctx,
   input  logic              i_not_flush,
   input  logic              i_stall,
   input  logic              i_reti,
   output logic              o_redirect,
   output logic [31:0]       o_iaddr,
   output logic              o_restore_cc,
   output logic [3:0]        o_restore_ccodes,
   output logic              o_in_isr
);

   import vic_pkg::*;

   vic_state_t state;
   cpu_ctx_t   saved_ctx;
   logic       take_new;  // Entry from idle
   logic       chain;     // Return straight into the next routine
   logic       ret;       // Return to the interrupted code

   // Routine address of a vector
   function automatic logic [31:0] isr_addr(input vec_t vec);
      return 32'(vec) << ISR_SHIFT;
   endfunction

   assign take_new = (state == ST_IDLE) && !i_empty && i_not_flush;
   assign chain    = (state == ST_IN_ISR) && i_reti && !i_empty;
   assign ret      = (state == ST_IN_ISR) && i_reti && i_empty;

   // Head is consumed on the same edge it is used
   assign o_pop = take_new || chain;

   ////////////////////////////////////////////////////////////
   // State and control outputs
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state        <= ST_IDLE;
         o_redirect   <= 1'b0;
         o_restore_cc <= 1'b0;
         o_in_isr     <= 1'b0;
      end
      else
      begin
         o_restore_cc <= 1'b0;  // Pulse only
         case (state)
            ST_IDLE:
            begin
               if (take_new)  // Waits out any bubble in execute
               begin
                  o_redirect <= 1'b1;
                  o_in_isr   <= 1'b1;
                  state      <= ST_ENTER;
               end
            end
            ST_ENTER:
            begin
               if (!i_stall)  // Fetch has taken the redirect
               begin
                  o_redirect <= 1'b0;
                  state      <= o_in_isr ? ST_IN_ISR : ST_IDLE;
               end
            end
            ST_IN_ISR:
            begin
               if (chain)
               begin
                  o_redirect <= 1'b1;
                  state      <= ST_ENTER;
               end
               else if (ret)
               begin
                  o_redirect   <= 1'b1;
                  o_restore_cc <= 1'b1;
                  o_in_isr     <= 1'b0;
                  state        <= ST_ENTER;
               end
            end
            default:
            begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Context and redirect target
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (take_new)
      begin
         saved_ctx <= i_ctx;  // Chained entries keep the first context
      end
      if (take_new || chain)
      begin
         o_iaddr <= isr_addr(i_head);
      end
      else if (ret)
      begin
         o_iaddr          <= saved_ctx.pc;
         o_restore_ccodes <= saved_ctx.ccodes;
      end
   end

endmodule

// File: source/vic.sv
`timescale 1ns/10ps

module vic
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic [vic_pkg::NUM_IRQ-1:0] i_irq,
   input  vic_pkg::cpu_ctx_t           i_ctx,
   input  logic                        i_not_flush,
   input  logic                        i_stall,
   input  logic                        i_reti,
   output logic                        o_redirect,
   output logic [31:0]                 o_iaddr,
   output logic                        o_restore_cc,
   output logic [3:0]                  o_restore_ccodes,
   output logic                        o_in_isr
);

   import vic_pkg::*;

   logic push;
   vec_t push_vec;
   logic full;
   logic empty;
   vec_t head;
   logic pop;

   ////////////////////////////////////////////////////////////
   // Capture, queue, CPU side control
   ////////////////////////////////////////////////////////////

   irq_prio prio_i
   (
      .clk        (clk),
      .rst        (rst),
      .i_irq      (i_irq),
      .i_full     (full),
      .o_push     (push),
      .o_push_vec (push_vec)
   );

   irq_queue #(.DEPTH(QUEUE_DEPTH_DEF)) queue_i
   (
      .clk        (clk),
      .rst        (rst),
      .i_push     (push),
      .i_push_vec (push_vec),
      .i_pop      (pop),
      .o_head     (head),
      .o_empty    (empty),
      .o_full     (full)
   );

   vic_ctrl ctrl_i
   (
      .clk              (clk),
      .rst              (rst),
      .i_head           (head),
      .i_empty          (empty),
      .o_pop            (pop),
      .i_ctx            (i_ctx),
      .i_not_flush      (i_not_flush),
      .i_stall          (i_stall),
      .i_reti           (i_reti),
      .o_redirect       (o_redirect),
      .o_iaddr          (o_iaddr),
      .o_restore_cc     (o_restore_cc),
      .o_restore_ccodes (o_restore_ccodes),
      .o_in_isr         (o_in_isr)
   );

endmodule

// File: tests/vic_asserts.sv
`timescale 1ns/10ps

module vic_asserts
(
   input logic clk,
   input logic rst,
   input logic o_restore_cc,
   input logic o_pop,
   input logic i_empty,
   input logic o_redirect,
   input logic i_stall
);

   restore_one_cycle: assert property (@(posedge clk) disable iff (rst)
      o_restore_cc |=> !o_restore_cc)
      else $error("o_restore_cc held for more than one cycle");

   // The head is only valid when the queue holds an entry
   pop_not_empty: assert property (@(posedge clk) disable iff (rst)
      o_pop |-> !i_empty)
      else $error("o_pop raised while the queue is empty");

   redirect_held_in_stall: assert property (@(posedge clk) disable iff (rst)
      $fell(o_redirect) |-> !$past(i_stall))
      else $error("o_redirect dropped while fetch was stalled");

endmodule

bind vic_ctrl vic_asserts asserts_i
(
   .clk          (clk),
   .rst          (rst),
   .o_restore_cc (o_restore_cc),
   .o_pop        (o_pop),
   .i_empty      (i_empty),
   .o_redirect   (o_redirect),
   .i_stall      (i_stall)
);

// File: tests/vic_checker.sv
`timescale 1ns/10ps

module vic_checker
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic [vic_pkg::NUM_IRQ-1:0] i_irq,
   input  vic_pkg::cpu_ctx_t           i_ctx,
   input  logic                        i_not_flush,
   input  logic                        i_stall,
   input  logic                        i_redirect,
   input  logic [31:0]                 i_iaddr,
   input  logic                        i_restore_cc,
   input  logic [3:0]                  i_restore_ccodes,
   input  logic                        i_in_isr,
   input  int                          i_test_id,
   input  logic                        i_test_end,
   input  logic                        i_check_lat,
   output int                          o_errors,
   output int                          o_checks
);

   import vic_pkg::*;

   vec_t               exp_q [$];  // Requests in service order
   cpu_ctx_t           saved;      // Context of the first entry
   cpu_ctx_t           ctx_q;
   logic [NUM_IRQ-1:0] irq_q;
   logic               nf_q;
   logic               stall_q;
   logic               red_q;
   logic [31:0]        iaddr_q;
   logic               in_isr_m;
   int                 cyc;
   int                 edge_cyc;
   int                 t_checks;
   int                 t_errors;

   task automatic check(input logic ok, input string msg);
      o_checks++;
      t_checks++;
      if (!ok)
      begin
         o_errors++;
         t_errors++;
         $display("** Error: %0d ns: %s", $time, msg);
      end
   endtask

   function automatic string test_name(input int id);
      case (id)
         1:       return "single entry";
         2:       return "return restore";
         3:       return "priority";
         4:       return "chaining";
         5:       return "flush deferral";
         default: return "stall hold";
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Reference model and comparison
   ////////////////////////////////////////////////////////////

   always @(posedge clk)
   begin
      vec_t        v;
      logic [31:0] exp_addr;
      if (rst)
      begin
         exp_q.delete();
         irq_q    <= '0;
         red_q    <= 1'b0;
         in_isr_m <= 1'b0;
         cyc      = 0;
         edge_cyc = 0;
         o_errors = 0;
         o_checks = 0;
         t_checks = 0;
         t_errors = 0;
      end
      else
      begin
         cyc++;
         // Simultaneous edges queue lowest line first
         if ((i_irq & ~irq_q) != '0)
         begin
            edge_cyc = cyc;
            for (int i = 0; i < NUM_IRQ; i++)
            begin
               if (i_irq[i] && !irq_q[i])
               begin
                  exp_q.push_back(vec_t'(i));
               end
            end
         end
         if (i_redirect && !red_q)
         begin
            if (!in_isr_m || exp_q.size() > 0)  // Entry or chain
            begin
               check(exp_q.size() > 0, "redirect with no request outstanding");
               v = (exp_q.size() > 0) ? exp_q.pop_front() : '0;
               exp_addr = 32'(v) * 32'd16;
               check(i_iaddr == exp_addr, $sformatf("vector %0d: iaddr %h, expected %h",
                     v, i_iaddr, exp_addr));
               check(i_in_isr && !i_restore_cc, "wrong flags at routine entry");
               if (!in_isr_m)
               begin
                  check(nf_q, "entry taken while execute stage was flushed");
                  if (i_check_lat)
                  begin
                     check(cyc - edge_cyc == 5, $sformatf("entry after %0d edges, expected 4",
                           cyc - edge_cyc - 1));
                  end
                  saved = ctx_q;
               end
               in_isr_m <= 1'b1;
            end
            else
            begin
               check(i_iaddr == saved.pc, $sformatf("return pc %h, expected %h",
                     i_iaddr, saved.pc));
               check(i_restore_cc && i_restore_ccodes == saved.ccodes,
                     $sformatf("restore codes %h (strobe %b), expected %h",
                     i_restore_ccodes, i_restore_cc, saved.ccodes));
               check(!i_in_isr, "o_in_isr still high after return");
               in_isr_m <= 1'b0;
            end
         end
         else if (i_restore_cc)
         begin
            check(1'b0, "o_restore_cc without a return");
         end
         if (red_q && stall_q)
         begin
            check(i_redirect && i_iaddr == iaddr_q, "redirect changed during stall");
         end
         if (i_test_end)
         begin
            check(exp_q.size() == 0 && !in_isr_m, "requests left at end of test");
            $display("Test %0d %s: %0d checks, %0d errors", i_test_id, test_name(i_test_id),
                     t_checks, t_errors);
            t_checks = 0;
            t_errors = 0;
         end
         irq_q   <= i_irq;
         ctx_q   <= i_ctx;
         nf_q    <= i_not_flush;
         stall_q <= i_stall;
         red_q   <= i_redirect;
         iaddr_q <= i_iaddr;
      end
   end

endmodule

// File: tests/vic_tb.sv
`timescale 1ns/10ps

module vic_tb;

   import vic_pkg::*;

   localparam int CLK_PERIOD = 10;
   localparam int NUM_TESTS  = 6;
   localparam int REPS       = 8;    // Bursts per test
   localparam int MAX_BURST  = 600;  // Worst case cycles for one burst
   localparam int MARGIN     = 2;

   logic               clk;
   logic               rst;
   logic [NUM_IRQ-1:0] i_irq;
   cpu_ctx_t           i_ctx;
   logic               i_not_flush;
   logic               i_stall;
   logic               i_reti;
   logic               o_redirect;
   logic [31:0]        o_iaddr;
   logic               o_restore_cc;
   logic [3:0]         o_restore_ccodes;
   logic               o_in_isr;

   logic [15:0]        lfsr;
   logic [NUM_IRQ-1:0] irq_next;
   logic               reti_next;
   logic               end_next;
   logic               test_end;
   logic               flush_en;
   logic               stall_en;
   logic               check_lat;
   int                 test_id;
   int                 flush_run;
   int                 stall_run;
   int                 errors;
   int                 checks;

   vic vic_i
   (
      .clk              (clk),
      .rst              (rst),
      .i_irq            (i_irq),
      .i_ctx            (i_ctx),
      .i_not_flush      (i_not_flush),
      .i_stall          (i_stall),
      .i_reti           (i_reti),
      .o_redirect       (o_redirect),
      .o_iaddr          (o_iaddr),
      .o_restore_cc     (o_restore_cc),
      .o_restore_ccodes (o_restore_ccodes),
      .o_in_isr         (o_in_isr)
   );

   vic_checker checker_i
   (
      .clk              (clk),
      .rst              (rst),
      .i_irq            (i_irq),
      .i_ctx            (i_ctx),
      .i_not_flush      (i_not_flush),
      .i_stall          (i_stall),
      .i_redirect       (o_redirect),
      .i_iaddr          (o_iaddr),
      .i_restore_cc     (o_restore_cc),
      .i_restore_ccodes (o_restore_ccodes),
      .i_in_isr         (o_in_isr),
      .i_test_id        (test_id),
      .i_test_end       (test_end),
      .i_check_lat      (check_lat),
      .o_errors         (errors),
      .o_checks         (checks)
   );

   // Taps 16, 14, 13, 11
   function automatic logic next_bit();
      logic b;
      b    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], b};
      return b;
   endfunction

   function automatic logic [35:0] rand_bits(input int n);
      logic [35:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v = {v[34:0], next_bit()};
      end
      return v;
   endfunction

   ////////////////////////////////////////////////////////////
   // CPU side, everything driven on the falling edge
   ////////////////////////////////////////////////////////////

   task automatic tick();
      @(negedge clk);
      i_irq     = irq_next;
      irq_next  = '0;
      i_reti    = reti_next;
      reti_next = 1'b0;
      test_end  = end_next;
      end_next  = 1'b0;
      i_ctx     = cpu_ctx_t'(rand_bits(36));
      if (flush_run == 0)  // Random runs of flushed slots
      begin
         i_not_flush = flush_en ? !i_not_flush : 1'b1;
         flush_run   = 1 + int'(rand_bits(3));
      end
      flush_run--;
      if (stall_run == 0)
      begin
         i_stall   = stall_en ? !i_stall : 1'b0;
         stall_run = 1 + int'(rand_bits(3));
      end
      stall_run--;
   endtask

   // One reti per queued routine, the last one returns
   task automatic serve(input int n);
      int len;
      for (int k = 0; k < n; k++)
      begin
         tick();
         while (!(o_in_isr && !o_redirect))
         begin
            tick();
         end
         len = 12 + int'(rand_bits(4));
         repeat (len) tick();
         reti_next = 1'b1;
         tick();
      end
      tick();
      while (o_in_isr || o_redirect)
      begin
         tick();
      end
      repeat (4) tick();
   endtask

   task automatic run_test(input int id);
      logic [NUM_IRQ-1:0] mask;
      test_id   = id;
      check_lat = (id == 1);
      flush_en  = (id == 5);
      stall_en  = (id != 1);
      flush_run = 0;
      stall_run = 0;
      repeat (REPS)
      begin
         if (id <= 2 || (id == 5 && next_bit()))
         begin
            mask = NUM_IRQ'(1) << rand_bits(3);
         end
         else if (id == 4)
         begin
            mask = NUM_IRQ'(rand_bits(8)) | 8'h81;  // At least two, often past full
         end
         else
         begin
            mask = NUM_IRQ'(rand_bits(8)) | (NUM_IRQ'(1) << rand_bits(3));
         end
         irq_next = mask;
         serve($countones(mask));
      end
      end_next = 1'b1;
      tick();
   endtask

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      lfsr        = 16'd37;
      rst         = 1'b1;
      i_irq       = '0;
      i_ctx       = '0;
      i_not_flush = 1'b1;
      i_stall     = 1'b0;
      i_reti      = 1'b0;
      irq_next    = '0;
      reti_next   = 1'b0;
      end_next    = 1'b0;
      test_end    = 1'b0;
      flush_en    = 1'b0;
      stall_en    = 1'b0;
      check_lat   = 1'b0;
      test_id     = 0;
      flush_run   = 0;
      stall_run   = 0;
      repeat (8) @(posedge clk);
      tick();
      rst = 1'b0;
      for (int id = 1; id <= NUM_TESTS; id++)
      begin
         run_test(id);
      end
      repeat (4) tick();
      $display("Tests: %0d  Checks: %0d  Errors: %0d", NUM_TESTS, checks, errors);
      if (errors == 0)
      begin
         $display("=== PASS ===");
      end
      else
      begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // Watchdog
   initial
   begin
      #(CLK_PERIOD * NUM_TESTS * REPS * MAX_BURST * MARGIN);
      $display("Timeout: the DUT stopped answering before all tests finished");
      $display("=== FAIL ===");
      $finish;
   end

endmodule

// File: vlog.f
source/vic_pkg.sv
source/irq_prio.sv
source/irq_queue.sv
source/vic_ctrl.sv
source/vic.sv
tests/vic_asserts.sv
tests/vic_checker.sv
tests/vic_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the vic testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module vic_tb -f vlog.f -o vic_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/vic_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
   exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
   echo "Simulation ended without a pass line"
   exit 1
fi
exit 0
